// File: cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data word width
`define CPU_XLEN 32

// General registers
`define CPU_NREGS 32

// Bits needed to address one register
`define CPU_RIDX 5

// Host AXI4-Lite address width
`define CPU_AXI_AW 8

`endif

// File: cpuPkg.sv
`default_nettype none

`include "cpuConsts.svh"

package cpuPkg;

  // Major opcodes of the subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f
  } opcodeE;

  // R-type function codes
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_ADD  = 6'h20,
    FN_ADDU = 6'h21,
    FN_SUB  = 6'h22,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } functE;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } aluOpE;

  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axiRespE;

  typedef enum logic {IDLE, RESP} axiWrStateE;

  // Instruction word in R-type layout; I-type immediate is {rd, shamt, funct}
  typedef struct packed {
    logic [5:0]           opcode;
    logic [`CPU_RIDX-1:0] rs;
    logic [`CPU_RIDX-1:0] rt;
    logic [`CPU_RIDX-1:0] rd;
    logic [4:0]           shamt;
    logic [5:0]           funct;
  } instrT;

  typedef struct packed {
    logic                 valid;
    aluOpE                aluOp;
    logic                 aluSrc;
    logic                 useShamt;
    logic [4:0]           shamt;
    logic                 regWrite;
    logic [`CPU_RIDX-1:0] dest;
    logic [`CPU_RIDX-1:0] rs;
    logic [`CPU_RIDX-1:0] rt;
    logic [`CPU_XLEN-1:0] readData1;
    logic [`CPU_XLEN-1:0] readData2;
    logic [`CPU_XLEN-1:0] imm;
  } idExT;

  typedef struct packed {
    logic                 regWrite;
    logic [`CPU_RIDX-1:0] dest;
    logic [`CPU_XLEN-1:0] result;
  } exWbT;

  // Registered R channel payload
  typedef struct packed {
    axiRespE              resp;
    logic [`CPU_XLEN-1:0] data;
  } axiRdRespT;

endpackage

`default_nettype wire

// File: axiLiteSlave.sv
`default_nettype none

`include "cpuConsts.svh"

module axiLiteSlave
  import cpuPkg::*;
(
  input  logic                    Clk,
  input  logic                    arstN,
  input  logic [`CPU_AXI_AW-1:0]  AWADDR,
  input  logic                    AWVALID,
  output logic                    AWREADY,
  input  logic [`CPU_XLEN-1:0]    WDATA,
  input  logic [`CPU_XLEN/8-1:0]  WSTRB,
  input  logic                    WVALID,
  output logic                    WREADY,
  output logic                    BVALID,
  output logic [1:0]              BRESP,
  input  logic                    BREADY,
  input  logic [`CPU_AXI_AW-1:0]  ARADDR,
  input  logic                    ARVALID,
  output logic                    ARREADY,
  output logic                    RVALID,
  output logic [`CPU_XLEN-1:0]    RDATA,
  output logic [1:0]              RRESP,
  input  logic                    RREADY,
  output logic                    instrValid,
  output logic [`CPU_XLEN-1:0]    instrWord,
  output logic [`CPU_RIDX-1:0]    hostRegIdx,
  input  logic [`CPU_XLEN-1:0]    hostRegData
);

  axiWrStateE wrState;
  axiRespE    bResp;
  logic       wrFire;
  logic       wrOk;
  logic       rValid;
  logic       arFire;
  logic       arInRange;
  axiRdRespT  rdResp;

  // Address and data are taken together, never one without the other
  assign wrFire  = (wrState == IDLE) && AWVALID && WVALID;
  assign AWREADY = wrFire;
  assign WREADY  = wrFire;
  assign wrOk    = (AWADDR == '0) && (&WSTRB);

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      wrState <= IDLE;
      bResp   <= OKAY;
    end else begin
      case (wrState)
        IDLE: begin
          if (wrFire) begin
            wrState <= RESP;
            bResp   <= wrOk ? OKAY : SLVERR;
          end
        end
        RESP: begin
          if (BREADY) begin
            wrState <= IDLE;
          end
        end
        default: wrState <= IDLE;
      endcase
    end
  end

  assign BVALID = (wrState == RESP);
  assign BRESP  = bResp;

  // One-cycle issue pulse into decode
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      instrValid <= 1'b0;
    end else begin
      instrValid <= wrFire && wrOk;
    end
  end

  always_ff @(posedge Clk) begin
    if (wrFire) begin
      instrWord <= WDATA;
    end
  end

  // Register read port, one word per register
  assign ARREADY    = !rValid;
  assign arFire     = ARVALID && ARREADY;
  assign hostRegIdx = ARADDR[`CPU_RIDX+1:2];
  assign arInRange  = (ARADDR[`CPU_AXI_AW-1:`CPU_RIDX+2] == '0);

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      rValid <= 1'b0;
    end else if (arFire) begin
      rValid <= 1'b1;
    end else if (RREADY) begin
      rValid <= 1'b0;
    end
  end

  always_ff @(posedge Clk) begin
    if (arFire) begin
      if (arInRange) begin
        rdResp <= '{resp: OKAY, data: hostRegData};
      end else begin
        rdResp <= '{resp: SLVERR, data: '0};
      end
    end
  end

  assign RVALID = rValid;
  assign RDATA  = rdResp.data;
  assign RRESP  = rdResp.resp;

  aBHold: assert property (@(posedge Clk) disable iff (!arstN)
    BVALID && !BREADY |=> BVALID && $stable(BRESP));

  aRHold: assert property (@(posedge Clk) disable iff (!arstN)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP));

endmodule

`default_nettype wire

// File: instrDecode.sv
`default_nettype none

`include "cpuConsts.svh"

module instrDecode
  import cpuPkg::*;
(
  input  logic                  Clk,
  input  logic                  arstN,
  input  logic                  instrValid,
  input  logic [`CPU_XLEN-1:0]  instrWord,
  output logic [`CPU_RIDX-1:0]  rsIdx,
  output logic [`CPU_RIDX-1:0]  rtIdx,
  input  logic [`CPU_XLEN-1:0]  rsData,
  input  logic [`CPU_XLEN-1:0]  rtData,
  output idExT                  idEx
);

  instrT                instr;
  logic [15:0]          imm16;
  logic [`CPU_XLEN-1:0] extImm;
  logic [`CPU_RIDX-1:0] dest;
  aluOpE                aluOp;
  logic                 aluSrc;
  logic                 useShamt;
  logic                 zeroExt;
  logic                 rType;
  logic                 known;

  assign instr = instrT'(instrWord);
  assign rsIdx = instr.rs;
  assign rtIdx = instr.rt;
  assign imm16 = {instr.rd, instr.shamt, instr.funct};

  always_comb begin
    aluOp    = ALU_ADD;
    aluSrc   = 1'b0;
    useShamt = 1'b0;
    zeroExt  = 1'b0;
    rType    = 1'b0;
    known    = 1'b1;
    case (instr.opcode)
      OP_SPECIAL: begin
        rType = 1'b1;
        case (instr.funct)
          FN_ADD, FN_ADDU: aluOp = ALU_ADD;
          FN_SUB, FN_SUBU: aluOp = ALU_SUB;
          FN_AND:          aluOp = ALU_AND;
          FN_OR:           aluOp = ALU_OR;
          FN_XOR:          aluOp = ALU_XOR;
          FN_NOR:          aluOp = ALU_NOR;
          FN_SLT:          aluOp = ALU_SLT;
          FN_SLTU:         aluOp = ALU_SLTU;
          FN_SLL: begin
            aluOp    = ALU_SLL;
            useShamt = 1'b1;
          end
          FN_SRL: begin
            aluOp    = ALU_SRL;
            useShamt = 1'b1;
          end
          FN_SRA: begin
            aluOp    = ALU_SRA;
            useShamt = 1'b1;
          end
          default: known = 1'b0;
        endcase
      end
      // No overflow trap, addi behaves like addiu
      OP_ADDI, OP_ADDIU: begin
        aluOp  = ALU_ADD;
        aluSrc = 1'b1;
      end
      OP_SLTI: begin
        aluOp  = ALU_SLT;
        aluSrc = 1'b1;
      end
      OP_ANDI: begin
        aluOp   = ALU_AND;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
      end
      OP_ORI: begin
        aluOp   = ALU_OR;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
      end
      OP_XORI: begin
        aluOp   = ALU_XOR;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
      end
      OP_LUI: begin
        aluOp   = ALU_LUI;
        aluSrc  = 1'b1;
        zeroExt = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // Logical immediates are zero extended
  assign extImm = zeroExt ? {{(`CPU_XLEN-16){1'b0}}, imm16}
                          : {{(`CPU_XLEN-16){imm16[15]}}, imm16};
  assign dest   = rType ? instr.rd : instr.rt;

  // ID/EX register
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      idEx.valid    <= 1'b0;
      idEx.aluOp    <= ALU_ADD;
      idEx.aluSrc   <= 1'b0;
      idEx.useShamt <= 1'b0;
      idEx.shamt    <= '0;
      idEx.regWrite <= 1'b0;
    end else begin
      idEx.valid     <= instrValid;
      idEx.aluOp     <= aluOp;
      idEx.aluSrc    <= aluSrc;
      idEx.useShamt  <= useShamt;
      idEx.shamt     <= instr.shamt;
      idEx.regWrite  <= instrValid && known && (dest != '0);
      idEx.dest      <= dest;
      idEx.rs        <= instr.rs;
      idEx.rt        <= instr.rt;
      idEx.readData1 <= rsData;
      idEx.readData2 <= rtData;
      idEx.imm       <= extImm;
    end
  end

  aNoZeroDest: assert property (@(posedge Clk) disable iff (!arstN)
    idEx.regWrite |-> idEx.valid && (idEx.dest != '0));

endmodule

`default_nettype wire

// File: aluExecute.sv
`default_nettype none

`include "cpuConsts.svh"

module aluExecute
  import cpuPkg::*;
(
  input  logic Clk,
  input  logic arstN,
  input  idExT idEx,
  output exWbT exWb
);

  logic [`CPU_XLEN-1:0] fwdRs;
  logic [`CPU_XLEN-1:0] fwdRt;
  logic [`CPU_XLEN-1:0] opA;
  logic [`CPU_XLEN-1:0] opB;
  logic [4:0]           shAmt;
  logic [`CPU_XLEN-1:0] aluResult;

  // Previous instruction's result bypasses the register file
  assign fwdRs = (exWb.regWrite && (exWb.dest != '0) && (exWb.dest == idEx.rs))
                 ? exWb.result : idEx.readData1;
  assign fwdRt = (exWb.regWrite && (exWb.dest != '0) && (exWb.dest == idEx.rt))
                 ? exWb.result : idEx.readData2;

  assign opA   = fwdRs;
  assign opB   = idEx.aluSrc ? idEx.imm : fwdRt;
  assign shAmt = idEx.useShamt ? idEx.shamt : opA[4:0];

  always_comb begin
    case (idEx.aluOp)
      ALU_ADD:  aluResult = opA + opB;
      ALU_SUB:  aluResult = opA - opB;
      ALU_AND:  aluResult = opA & opB;
      ALU_OR:   aluResult = opA | opB;
      ALU_XOR:  aluResult = opA ^ opB;
      ALU_NOR:  aluResult = ~(opA | opB);
      ALU_SLT:  aluResult = {{(`CPU_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      ALU_SLTU: aluResult = {{(`CPU_XLEN-1){1'b0}}, opA < opB};
      // Shifts operate on rt
      ALU_SLL:  aluResult = opB << shAmt;
      ALU_SRL:  aluResult = opB >> shAmt;
      ALU_SRA:  aluResult = $unsigned($signed(opB) >>> shAmt);
      ALU_LUI:  aluResult = {opB[15:0], 16'h0000};
      default:  aluResult = '0;
    endcase
  end

  // EX/WB register
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      exWb.regWrite <= 1'b0;
    end else begin
      exWb.regWrite <= idEx.regWrite;
      exWb.dest     <= idEx.dest;
      exWb.result   <= aluResult;
    end
  end

  aWbFollowsId: assert property (@(posedge Clk) disable iff (!arstN)
    exWb.regWrite |-> $past(idEx.valid));

endmodule

`default_nettype wire

// File: regFile.sv
`default_nettype none

`include "cpuConsts.svh"

module regFile
  import cpuPkg::*;
(
  input  logic                  Clk,
  input  logic                  arstN,
  input  exWbT                  exWb,
  input  logic [`CPU_RIDX-1:0]  rsIdx,
  input  logic [`CPU_RIDX-1:0]  rtIdx,
  input  logic [`CPU_RIDX-1:0]  hostRegIdx,
  output logic [`CPU_XLEN-1:0]  rsData,
  output logic [`CPU_XLEN-1:0]  rtData,
  output logic [`CPU_XLEN-1:0]  hostRegData
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  // Write-through covers the instruction two ahead
  function automatic logic [`CPU_XLEN-1:0] rdPort(input logic [`CPU_RIDX-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (exWb.regWrite && (exWb.dest == idx)) begin
      return exWb.result;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (exWb.regWrite && (exWb.dest != '0)) begin
      regs[exWb.dest] <= exWb.result;
    end
  end

  always_comb begin
    rsData      = rdPort(rsIdx);
    rtData      = rdPort(rtIdx);
    hostRegData = rdPort(hostRegIdx);
  end

endmodule

`default_nettype wire

// File: cpuTop.sv
`default_nettype none

`include "cpuConsts.svh"

module cpuTop
  import cpuPkg::*;
(
  input  logic                    Clk,
  input  logic                    arstN,
  input  logic [`CPU_AXI_AW-1:0]  AWADDR,
  input  logic                    AWVALID,
  output logic                    AWREADY,
  input  logic [`CPU_XLEN-1:0]    WDATA,
  input  logic [`CPU_XLEN/8-1:0]  WSTRB,
  input  logic                    WVALID,
  output logic                    WREADY,
  output logic                    BVALID,
  output logic [1:0]              BRESP,
  input  logic                    BREADY,
  input  logic [`CPU_AXI_AW-1:0]  ARADDR,
  input  logic                    ARVALID,
  output logic                    ARREADY,
  output logic                    RVALID,
  output logic [`CPU_XLEN-1:0]    RDATA,
  output logic [1:0]              RRESP,
  input  logic                    RREADY
);

  logic                 instrValid;
  logic [`CPU_XLEN-1:0] instrWord;
  logic [`CPU_RIDX-1:0] rsIdx;
  logic [`CPU_RIDX-1:0] rtIdx;
  logic [`CPU_RIDX-1:0] hostRegIdx;
  logic [`CPU_XLEN-1:0] rsData;
  logic [`CPU_XLEN-1:0] rtData;
  logic [`CPU_XLEN-1:0] hostRegData;
  idExT                 idEx;
  exWbT                 exWb;

  axiLiteSlave uSlave (
    .Clk         (Clk),
    .arstN       (arstN),
    .AWADDR      (AWADDR),
    .AWVALID     (AWVALID),
    .AWREADY     (AWREADY),
    .WDATA       (WDATA),
    .WSTRB       (WSTRB),
    .WVALID      (WVALID),
    .WREADY      (WREADY),
    .BVALID      (BVALID),
    .BRESP       (BRESP),
    .BREADY      (BREADY),
    .ARADDR      (ARADDR),
    .ARVALID     (ARVALID),
    .ARREADY     (ARREADY),
    .RVALID      (RVALID),
    .RDATA       (RDATA),
    .RRESP       (RRESP),
    .RREADY      (RREADY),
    .instrValid  (instrValid),
    .instrWord   (instrWord),
    .hostRegIdx  (hostRegIdx),
    .hostRegData (hostRegData)
  );

  instrDecode uDecode (
    .Clk        (Clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instrWord  (instrWord),
    .rsIdx      (rsIdx),
    .rtIdx      (rtIdx),
    .rsData     (rsData),
    .rtData     (rtData),
    .idEx       (idEx)
  );

  aluExecute uExecute (
    .Clk   (Clk),
    .arstN (arstN),
    .idEx  (idEx),
    .exWb  (exWb)
  );

  // Result stage is the register file write port
  regFile uRegFile (
    .Clk         (Clk),
    .arstN       (arstN),
    .exWb        (exWb),
    .rsIdx       (rsIdx),
    .rtIdx       (rtIdx),
    .hostRegIdx  (hostRegIdx),
    .rsData      (rsData),
    .rtData      (rtData),
    .hostRegData (hostRegData)
  );

endmodule

`default_nettype wire

// File: tbCpu.sv
`default_nettype none

`include "cpuConsts.svh"

module tbCpu
  import cpuPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles    = 16;
  localparam int handshakeLimit = 50;
  // Rough instruction total over all tests
  localparam int numInstr       = 250;
  localparam int watchdogCycles = resetCycles + numInstr * 20 + 2000;

  logic                   Clk;
  logic                   arstN;
  logic [`CPU_AXI_AW-1:0] AWADDR;
  logic [`CPU_AXI_AW-1:0] ARADDR;
  logic                   AWVALID, AWREADY, WVALID, WREADY;
  logic                   BVALID, BREADY, ARVALID, ARREADY, RVALID, RREADY;
  logic [`CPU_XLEN-1:0]   WDATA;
  logic [`CPU_XLEN-1:0]   RDATA;
  logic [`CPU_XLEN/8-1:0] WSTRB;
  logic [1:0]             BRESP;
  logic [1:0]             RRESP;

  logic [`CPU_XLEN-1:0] model [`CPU_NREGS];
  logic [31:0]          lfsrState;
  string                curTest;
  int                   errors;
  int                   checks;
  int                   tests;
  int                   testErrStart;

  logic [5:0] rFuncts [13] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                               FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
  logic [5:0] iOps [7]     = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
  // sltiu, j, lw, sw are outside the subset
  logic [5:0] badOps [4]   = '{6'h0b, 6'h02, 6'h23, 6'h2b};

  cpuTop UUT (
    .Clk(Clk), .arstN(arstN),
    .AWADDR(AWADDR), .AWVALID(AWVALID), .AWREADY(AWREADY),
    .WDATA(WDATA), .WSTRB(WSTRB), .WVALID(WVALID), .WREADY(WREADY),
    .BVALID(BVALID), .BRESP(BRESP), .BREADY(BREADY),
    .ARADDR(ARADDR), .ARVALID(ARVALID), .ARREADY(ARREADY),
    .RVALID(RVALID), .RDATA(RDATA), .RRESP(RRESP), .RREADY(RREADY)
  );

  initial begin
    Clk = 1'b0;
    forever #20 Clk = ~Clk;
  end

  initial begin
    repeat (watchdogCycles) @(posedge Clk);
    $display("ERROR watchdog: simulation did not finish within %0d cycles", watchdogCycles);
    $display("Checks failed");
    $finish;
  end

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] rOp(input functE fn, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] shOp(input functE fn, input logic [4:0] rd,
                                       input logic [4:0] rt, input logic [4:0] sh);
    return {6'h00, 5'd0, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] iOp(input opcodeE op, input logic [4:0] rt,
                                      input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] randInstr();
    logic [3:0]  kind;
    logic [4:0]  rs, rt, rd, sh;
    logic [15:0] imm;
    int          idx;
    kind = 4'(randBits(4));
    rs   = 5'(randBits(5));
    rt   = 5'(randBits(5));
    rd   = 5'(randBits(5));
    sh   = 5'(randBits(5));
    imm  = 16'(randBits(16));
    idx  = int'(randBits(4));
    if (kind < 4'd8) begin
      return {6'h00, rs, rt, rd, sh, rFuncts[idx % 13]};
    end else if (kind < 4'd14) begin
      return {iOps[idx % 7], rs, rt, imm};
    end else if (idx[0]) begin
      // mult is not in the subset
      return {6'h00, rs, rt, rd, sh, 6'h18};
    end else begin
      return {badOps[idx % 4], rs, rt, imm};
    end
  endfunction

  // MIPS32 semantics of the subset, no traps
  task automatic modelApply(input logic [31:0] word);
    logic [5:0]  op, fn;
    logic [4:0]  rs, rt, rd, sh, dest;
    logic [31:0] a, b, sext, zext, res;
    logic        known;
    op = word[31:26];
    rs = word[25:21];
    rt = word[20:16];
    rd = word[15:11];
    sh = word[10:6];
    fn = word[5:0];
    a = model[rs];
    b = model[rt];
    sext = {{16{word[15]}}, word[15:0]};
    zext = {16'h0000, word[15:0]};
    known = 1'b1;
    dest = rt;
    res = '0;
    case (op)
      6'h00: begin
        dest = rd;
        case (fn)
          6'h00: res = b << sh;
          6'h02: res = b >> sh;
          6'h03: res = $unsigned($signed(b) >>> sh);
          6'h20, 6'h21: res = a + b;
          6'h22, 6'h23: res = a - b;
          6'h24: res = a & b;
          6'h25: res = a | b;
          6'h26: res = a ^ b;
          6'h27: res = ~(a | b);
          6'h2a: res = {31'd0, $signed(a) < $signed(b)};
          6'h2b: res = {31'd0, a < b};
          default: known = 1'b0;
        endcase
      end
      6'h08, 6'h09: res = a + sext;
      6'h0a: res = {31'd0, $signed(a) < $signed(sext)};
      6'h0c: res = a & zext;
      6'h0d: res = a | zext;
      6'h0e: res = a ^ zext;
      6'h0f: res = {word[15:0], 16'h0000};
      default: known = 1'b0;
    endcase
    if (known && dest != 5'd0) begin
      model[dest] = res;
    end
  endtask

  // Entered and left on a falling edge
  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int hold, output logic [1:0] resp);
    int   waited;
    logic accepted;
    AWADDR  = addr;
    WDATA   = data;
    WSTRB   = strb;
    AWVALID = 1'b1;
    WVALID  = 1'b1;
    BREADY  = 1'b0;
    waited  = 0;
    // Ready is sampled at the rising edge that takes the handshake
    @(posedge Clk);
    while (!(AWREADY && WREADY) && waited < handshakeLimit) begin
      @(posedge Clk);
      waited++;
    end
    accepted = AWREADY && WREADY;
    @(negedge Clk);
    AWVALID = 1'b0;
    WVALID  = 1'b0;
    if (!accepted) begin
      errors++;
      resp = 2'b11;
      $display("ERROR %s: write not accepted after %0d cycles", curTest, handshakeLimit);
    end else if (!BVALID) begin
      errors++;
      resp = 2'b11;
      $display("ERROR %s: no write response the cycle after the handshake", curTest);
    end else begin
      resp = BRESP;
      repeat (hold) begin
        @(negedge Clk);
        checkEq("bvalid held", 32'd1, 32'(BVALID));
        checkEq("bresp held", 32'(resp), 32'(BRESP));
      end
      BREADY = 1'b1;
      @(negedge Clk);
      BREADY = 1'b0;
    end
  endtask

  task automatic axiRead(input logic [7:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
    int   waited;
    logic accepted;
    ARADDR  = addr;
    ARVALID = 1'b1;
    RREADY  = 1'b0;
    waited  = 0;
    @(posedge Clk);
    while (!ARREADY && waited < handshakeLimit) begin
      @(posedge Clk);
      waited++;
    end
    accepted = ARREADY;
    @(negedge Clk);
    ARVALID = 1'b0;
    if (!accepted) begin
      errors++;
      data = 'x;
      resp = 2'b11;
      $display("ERROR %s: read address not accepted after %0d cycles", curTest, handshakeLimit);
    end else if (!RVALID) begin
      errors++;
      data = 'x;
      resp = 2'b11;
      $display("ERROR %s: no read data the cycle after the handshake", curTest);
    end else begin
      data = RDATA;
      resp = RRESP;
      repeat (hold) begin
        @(negedge Clk);
        checkEq("rvalid held", 32'd1, 32'(RVALID));
        checkEq("rdata held", data, RDATA);
        checkEq("rresp held", 32'(resp), 32'(RRESP));
      end
      RREADY = 1'b1;
      @(negedge Clk);
      RREADY = 1'b0;
    end
  endtask

  task automatic issue(input logic [31:0] word);
    logic [1:0] resp;
    axiWrite(8'h00, word, 4'hf, 0, resp);
    checkEq("issue bresp", 32'(OKAY), 32'(resp));
    modelApply(word);
  endtask

  task automatic compareAllRegs();
    logic [31:0] data;
    logic [1:0]  resp;
    // Last result reaches the register file three edges after acceptance
    repeat (4) @(negedge Clk);
    for (int i = 0; i < `CPU_NREGS; i++) begin
      axiRead(8'(i * 4), 0, data, resp);
      checkEq($sformatf("r%0d", i), model[5'(i)], data);
      checkEq($sformatf("r%0d rresp", i), 32'(OKAY), 32'(resp));
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrStart = errors;
    tests++;
  endtask

  task automatic endTest();
    $display("Test %s finished with %0d errors", curTest, errors - testErrStart);
  endtask

  task automatic resetState();
    logic [31:0] data;
    logic [1:0]  resp;
    startTest("resetState");
    compareAllRegs();
    axiRead(8'h80, 0, data, resp);
    checkEq("0x80 rresp", 32'(SLVERR), 32'(resp));
    checkEq("0x80 rdata", 32'd0, data);
    axiRead(8'hfc, 0, data, resp);
    checkEq("0xfc rresp", 32'(SLVERR), 32'(resp));
    endTest();
  endtask

  task automatic immediateOps();
    startTest("immediateOps");
    issue(iOp(OP_ADDI, 5'd1, 5'd0, 16'hfffb));
    issue(iOp(OP_ADDIU, 5'd2, 5'd1, 16'h7fff));
    issue(iOp(OP_ANDI, 5'd3, 5'd1, 16'hf0f0));
    issue(iOp(OP_ORI, 5'd4, 5'd0, 16'h8001));
    issue(iOp(OP_XORI, 5'd5, 5'd1, 16'hffff));
    issue(iOp(OP_SLTI, 5'd6, 5'd1, 16'h0001));
    issue(iOp(OP_SLTI, 5'd7, 5'd4, 16'hffff));
    issue(iOp(OP_LUI, 5'd8, 5'd0, 16'h8123));
    issue(iOp(OP_ADDI, 5'd9, 5'd8, 16'h8000));
    compareAllRegs();
    endTest();
  endtask

  task automatic rTypeChain();
    startTest("rTypeChain");
    issue(iOp(OP_LUI, 5'd10, 5'd0, 16'h1234));
    issue(iOp(OP_ORI, 5'd10, 5'd10, 16'h5678));
    issue(iOp(OP_ORI, 5'd11, 5'd0, 16'h00ff));
    issue(rOp(FN_ADD, 5'd12, 5'd10, 5'd11));
    issue(rOp(FN_SUB, 5'd13, 5'd12, 5'd10));
    issue(rOp(FN_AND, 5'd14, 5'd13, 5'd12));
    issue(rOp(FN_OR, 5'd15, 5'd14, 5'd11));
    issue(rOp(FN_XOR, 5'd16, 5'd15, 5'd12));
    issue(rOp(FN_NOR, 5'd17, 5'd16, 5'd13));
    issue(rOp(FN_SLT, 5'd18, 5'd17, 5'd16));
    issue(rOp(FN_SLTU, 5'd19, 5'd17, 5'd16));
    issue(rOp(FN_ADDU, 5'd20, 5'd19, 5'd18));
    issue(rOp(FN_SUBU, 5'd21, 5'd20, 5'd17));
    compareAllRegs();
    endTest();
  endtask

  task automatic shifts();
    startTest("shifts");
    issue(iOp(OP_LUI, 5'd22, 5'd0, 16'h8000));
    issue(iOp(OP_ORI, 5'd22, 5'd22, 16'h0001));
    issue(iOp(OP_ORI, 5'd23, 5'd0, 16'h7001));
    issue(shOp(FN_SLL, 5'd24, 5'd22, 5'd0));
    issue(shOp(FN_SLL, 5'd25, 5'd23, 5'd31));
    issue(shOp(FN_SRL, 5'd26, 5'd22, 5'd1));
    issue(shOp(FN_SRL, 5'd27, 5'd22, 5'd31));
    issue(shOp(FN_SRA, 5'd28, 5'd22, 5'd1));
    issue(shOp(FN_SRA, 5'd29, 5'd22, 5'd31));
    issue(shOp(FN_SRA, 5'd30, 5'd23, 5'd31));
    issue(shOp(FN_SLL, 5'd31, 5'd22, 5'd1));
    compareAllRegs();
    endTest();
  endtask

  task automatic randomStream();
    startTest("randomStream");
    for (int i = 0; i < 200; i++) begin
      issue(randInstr());
    end
    compareAllRegs();
    endTest();
  endtask

  task automatic axiErrors();
    logic [31:0] data;
    logic [1:0]  resp;
    startTest("axiErrors");
    axiWrite(8'h04, iOp(OP_ORI, 5'd1, 5'd0, 16'h1111), 4'hf, 0, resp);
    checkEq("addr 0x04 bresp", 32'(SLVERR), 32'(resp));
    axiWrite(8'h40, iOp(OP_ORI, 5'd2, 5'd0, 16'h2222), 4'hf, 0, resp);
    checkEq("addr 0x40 bresp", 32'(SLVERR), 32'(resp));
    axiWrite(8'h00, iOp(OP_ORI, 5'd3, 5'd0, 16'h3333), 4'h7, 0, resp);
    checkEq("strobe bresp", 32'(SLVERR), 32'(resp));
    compareAllRegs();
    // Stalled B and R channels
    axiWrite(8'h00, iOp(OP_ORI, 5'd5, 5'd0, 16'h5a5a), 4'hf, 6, resp);
    checkEq("held bresp", 32'(OKAY), 32'(resp));
    modelApply(iOp(OP_ORI, 5'd5, 5'd0, 16'h5a5a));
    repeat (4) @(negedge Clk);
    axiRead(8'h14, 7, data, resp);
    checkEq("held rdata", model[5], data);
    checkEq("held rresp", 32'(OKAY), 32'(resp));
    endTest();
  endtask

  initial begin
    arstN     = 1'b0;
    AWADDR    = '0;
    AWVALID   = 1'b0;
    WDATA     = '0;
    WSTRB     = '0;
    WVALID    = 1'b0;
    BREADY    = 1'b0;
    ARADDR    = '0;
    ARVALID   = 1'b0;
    RREADY    = 1'b0;
    lfsrState = 32'h32e7_30e7;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    curTest   = "none";
    for (int i = 0; i < `CPU_NREGS; i++) begin
      model[5'(i)] = '0;
    end
    repeat (resetCycles) @(posedge Clk);
    @(negedge Clk);
    arstN = 1'b1;
    @(negedge Clk);

    resetState();
    immediateOps();
    rTypeChain();
    shifts();
    randomStream();
    axiErrors();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cpuPkg.sv
axiLiteSlave.sv
instrDecode.sv
aluExecute.sv
regFile.sv
cpuTop.sv
tbCpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbCpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All checks passed

SRCS := $(filter-out +incdir+%,$(shell cat vlog.f))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) cpuConsts.svh vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
